// File: cache_sys_pkg.sv
/* shared widths, bus and cpu request structs, region decode
   and the fetch command helper for the cache subsystem */
`default_nettype none

package cache_sys_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int LINE_W = 128;

  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

  // bytes field holds size minus one: 0, 1, 3 or 7
  localparam logic [2:0] BYTES_WORD = 3'd3;
  // bus size is log2 of bytes, 4 is a whole line
  localparam logic [2:0] SIZE_LINE  = 3'd4;

  typedef enum logic [1:0] {
    REG_PERI,
    REG_FLASH,
    REG_MEM,
    REG_NONE
  } region_e;

  typedef struct packed {
    logic              op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [2:0]        bytes;
  } cpu_req_t;

  typedef struct packed {
    logic              op;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] wdata;
    logic [2:0]        size;
  } bus_req_t;

  function automatic region_e addr_region(logic [ADDR_W-1:0] addr);
    if (addr[31]) begin
      return REG_MEM;
    end
    case (addr[31:28])
      4'h1, 4'h2: return REG_PERI;
      4'h3:       return REG_FLASH;
      default:    return REG_NONE;
    endcase
  endfunction

  // instruction fetch as a 4-byte read
  function automatic cpu_req_t fetch_cmd(logic [ADDR_W-1:0] addr);
    cpu_req_t cmd;
    cmd.op    = OP_READ;
    cmd.addr  = addr;
    cmd.wdata = '0;
    cmd.bytes = BYTES_WORD;
    return cmd;
  endfunction

endpackage

`default_nettype wire

// File: cache_core.sv
/* direct-mapped cache core, write-back when writable,
   with dirty-line flush sweep and valid invalidate */
`timescale 1ns/100ps
`default_nettype none

module cache_core #(
  parameter int LINES    = 16,
  parameter bit WRITABLE = 1'b1
) (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_req,
  input  cache_sys_pkg::cpu_req_t          i_cmd,
  output logic                             o_ack,
  output logic [cache_sys_pkg::DATA_W-1:0] o_rdata,
  output logic                             o_bus_valid,
  output cache_sys_pkg::bus_req_t          o_bus,
  input  logic                             i_bus_ready,
  input  logic [cache_sys_pkg::LINE_W-1:0] i_bus_rdata,
  input  logic                             i_flush_req,
  input  logic                             i_inval,
  output logic                             o_flush_done
);
  import cache_sys_pkg::*;

  localparam int LINE_B = LINE_W / 8;
  localparam int OFFS_W = $clog2(LINE_B);
  localparam int IDX_W  = $clog2(LINES);
  localparam int TAG_W  = ADDR_W - IDX_W - OFFS_W;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WB,
    S_REFILL,
    S_FLUSH
  } state_e;

  state_e            state_q;
  logic [LINE_W-1:0] data_q [LINES];
  logic [TAG_W-1:0]  tag_q  [LINES];
  logic [LINES-1:0]  valid_q;
  logic [LINES-1:0]  dirty_q;
  logic [IDX_W-1:0]  sweep_q;

  logic [TAG_W-1:0]  tag;
  logic [IDX_W-1:0]  idx;
  logic [OFFS_W-1:0] offs;
  logic              lookup;
  logic              hit;
  logic              do_write;
  logic [LINE_B-1:0] byte_en;
  logic [LINE_W-1:0] bit_en;
  logic [LINE_W-1:0] wr_line;
  logic [LINE_W-1:0] rd_line;
  logic [IDX_W-1:0]  bus_idx;

  assign {tag, idx, offs} = i_cmd.addr;

  // a request is looked up once, the ack cycle is skipped
  assign lookup   = (state_q == S_IDLE) && i_req && !o_ack;
  assign hit      = valid_q[idx] && (tag_q[idx] == tag);
  assign do_write = WRITABLE && lookup && hit && (i_cmd.op == OP_WRITE);

  assign rd_line = data_q[idx] >> {offs, 3'b000};
  assign byte_en = ((LINE_B'(2) << i_cmd.bytes) - 1'b1) << offs;

  always_comb begin
    for (int b = 0; b < LINE_B; b++) begin
      bit_en[8*b +: 8] = {8{byte_en[b]}};
    end
    wr_line = (data_q[idx] & ~bit_en) |
              ((LINE_W'(i_cmd.wdata) << {offs, 3'b000}) & bit_en);
  end

  ////////////////////////////////////////////////////////////
  // bus side

  assign bus_idx     = (state_q == S_FLUSH) ? sweep_q : idx;
  assign o_bus_valid = (state_q == S_WB) || (state_q == S_REFILL) ||
                       ((state_q == S_FLUSH) && valid_q[sweep_q] && dirty_q[sweep_q]);

  always_comb begin
    o_bus.op    = (state_q == S_REFILL) ? OP_READ : OP_WRITE;
    o_bus.wdata = data_q[bus_idx];
    o_bus.size  = SIZE_LINE;
    if (state_q == S_REFILL) begin
      o_bus.addr = {tag, idx, OFFS_W'(0)};
    end else begin
      // victim line address
      o_bus.addr = {tag_q[bus_idx], bus_idx, OFFS_W'(0)};
    end
  end

  ////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q      <= S_IDLE;
      valid_q      <= '0;
      dirty_q      <= '0;
      sweep_q      <= '0;
      o_ack        <= 1'b0;
      o_flush_done <= 1'b0;
    end else begin
      o_ack        <= 1'b0;
      o_flush_done <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (lookup) begin
            if (hit) begin
              o_ack <= 1'b1;
              if (do_write) begin
                dirty_q[idx] <= 1'b1;
              end
            end else if (WRITABLE && valid_q[idx] && dirty_q[idx]) begin
              state_q <= S_WB;
            end else begin
              state_q <= S_REFILL;
            end
          end else if (WRITABLE && i_flush_req && !o_flush_done) begin
            state_q <= S_FLUSH;
            sweep_q <= '0;
          end
        end
        S_WB: begin
          if (i_bus_ready) begin
            dirty_q[idx] <= 1'b0;
            state_q      <= S_REFILL;
          end
        end
        S_REFILL: begin
          // back to idle, the held request then hits
          if (i_bus_ready) begin
            valid_q[idx] <= 1'b1;
            state_q      <= S_IDLE;
          end
        end
        S_FLUSH: begin
          // clean lines are passed over in one cycle
          if (!o_bus_valid || i_bus_ready) begin
            dirty_q[sweep_q] <= 1'b0;
            sweep_q          <= sweep_q + 1'b1;
            if (sweep_q == IDX_W'(LINES - 1)) begin
              state_q      <= S_IDLE;
              o_flush_done <= 1'b1;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
      if (i_inval) begin
        valid_q <= '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // line storage and read data

  always_ff @(posedge clk) begin
    if ((state_q == S_REFILL) && i_bus_ready) begin
      data_q[idx] <= i_bus_rdata;
      tag_q[idx]  <= tag;
    end else if (do_write) begin
      data_q[idx] <= wr_line;
    end
    if (lookup && hit) begin
      o_rdata <= rd_line[DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: cache_uncached.sv
/* uncached single-word access to the peripheral region */
`timescale 1ns/100ps
`default_nettype none

module cache_uncached (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_req,
  input  cache_sys_pkg::cpu_req_t          i_cmd,
  output logic                             o_ack,
  output logic [cache_sys_pkg::DATA_W-1:0] o_rdata,
  output logic                             o_bus_valid,
  output cache_sys_pkg::bus_req_t          o_bus,
  input  logic                             i_bus_ready,
  input  logic [cache_sys_pkg::LINE_W-1:0] i_bus_rdata
);
  import cache_sys_pkg::*;

  logic       accept;
  logic [2:0] size;

  assign accept = i_req && !o_ack && !o_bus_valid;

  // size minus one to log2 size
  always_comb begin
    if (i_cmd.bytes[2]) begin
      size = 3'd3;
    end else if (i_cmd.bytes[1]) begin
      size = 3'd2;
    end else begin
      size = {2'b00, i_cmd.bytes[0]};
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bus_valid <= 1'b0;
      o_ack       <= 1'b0;
    end else begin
      o_ack <= o_bus_valid && i_bus_ready;
      if (accept) begin
        o_bus_valid <= 1'b1;
      end else if (i_bus_ready) begin
        o_bus_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_bus.op    <= i_cmd.op;
      o_bus.addr  <= i_cmd.addr;
      o_bus.wdata <= LINE_W'(i_cmd.wdata);
      o_bus.size  <= size;
    end
    // word sits in the low line bits
    if (o_bus_valid && i_bus_ready) begin
      o_rdata <= i_bus_rdata[DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: cache_flush.sv
/* fence.i sequencer: dcache write-back sweep, then icache invalidate */
`timescale 1ns/100ps
`default_nettype none

module cache_flush (
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_fencei_req,
  output logic o_fencei_ack,
  output logic o_flush_req,
  input  logic i_flush_done,
  output logic o_inval
);

  typedef enum logic [1:0] {
    F_IDLE,
    F_FLUSH,
    F_INVAL
  } state_e;

  state_e state_q;

  assign o_flush_req = (state_q == F_FLUSH);
  assign o_inval     = (state_q == F_INVAL);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q      <= F_IDLE;
      o_fencei_ack <= 1'b0;
    end else begin
      o_fencei_ack <= 1'b0;
      case (state_q)
        F_IDLE: begin
          // req is still high in the ack cycle
          if (i_fencei_req && !o_fencei_ack) begin
            state_q <= F_FLUSH;
          end
        end
        F_FLUSH: begin
          if (i_flush_done) begin
            state_q <= F_INVAL;
          end
        end
        F_INVAL: begin
          state_q      <= F_IDLE;
          o_fencei_ack <= 1'b1;
        end
        default: state_q <= F_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: cache_route.sv
/* region decode, request steering to caches or uncached path,
   response return and held grant of the shared bus */
`timescale 1ns/100ps
`default_nettype none

module cache_route (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_if_req,
  input  logic [cache_sys_pkg::ADDR_W-1:0] i_if_addr,
  input  logic                             i_d_req,
  input  cache_sys_pkg::cpu_req_t          i_d_cmd,
  output logic                             o_ic_req,
  output logic                             o_dc_req,
  output logic                             o_uc_req,
  output cache_sys_pkg::cpu_req_t          o_uc_cmd,
  input  logic                             i_ic_ack,
  input  logic [cache_sys_pkg::DATA_W-1:0] i_ic_rdata,
  input  logic                             i_dc_ack,
  input  logic [cache_sys_pkg::DATA_W-1:0] i_dc_rdata,
  input  logic                             i_uc_ack,
  input  logic [cache_sys_pkg::DATA_W-1:0] i_uc_rdata,
  input  logic                             i_ic_bus_valid,
  input  cache_sys_pkg::bus_req_t          i_ic_bus,
  input  logic                             i_dc_bus_valid,
  input  cache_sys_pkg::bus_req_t          i_dc_bus,
  input  logic                             i_uc_bus_valid,
  input  cache_sys_pkg::bus_req_t          i_uc_bus,
  output logic                             o_ic_bus_ready,
  output logic                             o_dc_bus_ready,
  output logic                             o_uc_bus_ready,
  output logic                             o_bus_valid,
  output cache_sys_pkg::bus_req_t          o_bus_req,
  input  logic                             i_bus_ready,
  output logic                             o_if_ack,
  output logic [31:0]                      o_if_rdata,
  output logic                             o_d_ack,
  output logic [cache_sys_pkg::DATA_W-1:0] o_d_rdata
);
  import cache_sys_pkg::*;

  typedef enum logic [1:0] {
    G_NONE,
    G_DC,
    G_IC,
    G_UC
  } grant_e;

  region_e if_reg;
  region_e d_reg;
  logic    if_uc;
  logic    d_uc;
  logic    use_d;
  logic    uc_busy_q;
  logic    uc_sel_q;
  grant_e  grant_q;

  ////////////////////////////////////////////////////////////
  // request steering

  assign if_reg = addr_region(i_if_addr);
  assign d_reg  = addr_region(i_d_cmd.addr);

  assign o_ic_req = i_if_req && ((if_reg == REG_FLASH) || (if_reg == REG_MEM));
  assign o_dc_req = i_d_req && ((d_reg == REG_FLASH) || (d_reg == REG_MEM));
  assign if_uc    = i_if_req && (if_reg == REG_PERI);
  assign d_uc     = i_d_req && (d_reg == REG_PERI);

  // instruction first when both are peripheral, then held until ack
  assign use_d    = uc_busy_q ? uc_sel_q : !if_uc;
  assign o_uc_req = use_d ? d_uc : if_uc;
  assign o_uc_cmd = use_d ? i_d_cmd : fetch_cmd(i_if_addr);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      uc_busy_q <= 1'b0;
      uc_sel_q  <= 1'b0;
    end else if (!uc_busy_q && o_uc_req) begin
      uc_busy_q <= 1'b1;
      uc_sel_q  <= use_d;
    end else if (i_uc_ack) begin
      uc_busy_q <= 1'b0;
    end
  end

  assign o_if_ack   = i_ic_ack || (i_uc_ack && !uc_sel_q);
  assign o_if_rdata = i_ic_ack ? i_ic_rdata[31:0] : i_uc_rdata[31:0];
  assign o_d_ack    = i_dc_ack || (i_uc_ack && uc_sel_q);
  assign o_d_rdata  = i_dc_ack ? i_dc_rdata : i_uc_rdata;

  ////////////////////////////////////////////////////////////
  // bus grant

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      grant_q <= G_NONE;
    end else if (grant_q == G_NONE) begin
      if (i_dc_bus_valid) begin
        grant_q <= G_DC;
      end else if (i_ic_bus_valid) begin
        grant_q <= G_IC;
      end else if (i_uc_bus_valid) begin
        grant_q <= G_UC;
      end
    end else if (i_bus_ready) begin
      grant_q <= G_NONE;
    end
  end

  assign o_dc_bus_ready = i_bus_ready && (grant_q == G_DC);
  assign o_ic_bus_ready = i_bus_ready && (grant_q == G_IC);
  assign o_uc_bus_ready = i_bus_ready && (grant_q == G_UC);

  always_comb begin
    case (grant_q)
      G_DC: begin
        o_bus_valid = i_dc_bus_valid;
        o_bus_req   = i_dc_bus;
      end
      G_IC: begin
        o_bus_valid = i_ic_bus_valid;
        o_bus_req   = i_ic_bus;
      end
      G_UC: begin
        o_bus_valid = i_uc_bus_valid;
        o_bus_req   = i_uc_bus;
      end
      default: begin
        o_bus_valid = 1'b0;
        o_bus_req   = i_uc_bus;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: cache_top.sv
/* cache subsystem top: route, icache, dcache, uncached path
   and fence.i sequencer */
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
  parameter int ICACHE_LINES = 16,
  parameter int DCACHE_LINES = 16
) (
  input  logic                             clk,
  input  logic                             i_arst_n,
  input  logic                             i_if_req,
  input  logic [cache_sys_pkg::ADDR_W-1:0] i_if_addr,
  output logic                             o_if_ack,
  output logic [31:0]                      o_if_rdata,
  input  logic                             i_d_req,
  input  cache_sys_pkg::cpu_req_t          i_d_cmd,
  output logic                             o_d_ack,
  output logic [cache_sys_pkg::DATA_W-1:0] o_d_rdata,
  input  logic                             i_fencei_req,
  output logic                             o_fencei_ack,
  output logic                             o_bus_valid,
  output cache_sys_pkg::bus_req_t          o_bus_req,
  input  logic                             i_bus_ready,
  input  logic [cache_sys_pkg::LINE_W-1:0] i_bus_rdata
);
  import cache_sys_pkg::*;

  cpu_req_t          if_cmd;
  cpu_req_t          uc_cmd;
  logic              ic_req, dc_req, uc_req;
  logic              ic_ack, dc_ack, uc_ack;
  logic [DATA_W-1:0] ic_rdata, dc_rdata, uc_rdata;
  logic              ic_bus_valid, dc_bus_valid, uc_bus_valid;
  bus_req_t          ic_bus, dc_bus, uc_bus;
  logic              ic_bus_ready, dc_bus_ready, uc_bus_ready;
  logic              flush_req, flush_done, inval;

  assign if_cmd = fetch_cmd(i_if_addr);

  cache_route u_route (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_if_req (i_if_req), .i_if_addr (i_if_addr),
    .i_d_req (i_d_req), .i_d_cmd (i_d_cmd),
    .o_ic_req (ic_req), .o_dc_req (dc_req),
    .o_uc_req (uc_req), .o_uc_cmd (uc_cmd),
    .i_ic_ack (ic_ack), .i_ic_rdata (ic_rdata),
    .i_dc_ack (dc_ack), .i_dc_rdata (dc_rdata),
    .i_uc_ack (uc_ack), .i_uc_rdata (uc_rdata),
    .i_ic_bus_valid (ic_bus_valid), .i_ic_bus (ic_bus),
    .i_dc_bus_valid (dc_bus_valid), .i_dc_bus (dc_bus),
    .i_uc_bus_valid (uc_bus_valid), .i_uc_bus (uc_bus),
    .o_ic_bus_ready (ic_bus_ready), .o_dc_bus_ready (dc_bus_ready),
    .o_uc_bus_ready (uc_bus_ready),
    .o_bus_valid (o_bus_valid), .o_bus_req (o_bus_req), .i_bus_ready (i_bus_ready),
    .o_if_ack (o_if_ack), .o_if_rdata (o_if_rdata),
    .o_d_ack (o_d_ack), .o_d_rdata (o_d_rdata)
  );

  // read-only, cleared by fence.i
  cache_core #(.LINES (ICACHE_LINES), .WRITABLE (1'b0)) ICache (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_req (ic_req), .i_cmd (if_cmd), .o_ack (ic_ack), .o_rdata (ic_rdata),
    .o_bus_valid (ic_bus_valid), .o_bus (ic_bus),
    .i_bus_ready (ic_bus_ready), .i_bus_rdata (i_bus_rdata),
    .i_flush_req (1'b0), .i_inval (inval), .o_flush_done ()
  );

  cache_core #(.LINES (DCACHE_LINES), .WRITABLE (1'b1)) DCache (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_req (dc_req), .i_cmd (i_d_cmd), .o_ack (dc_ack), .o_rdata (dc_rdata),
    .o_bus_valid (dc_bus_valid), .o_bus (dc_bus),
    .i_bus_ready (dc_bus_ready), .i_bus_rdata (i_bus_rdata),
    .i_flush_req (flush_req), .i_inval (1'b0), .o_flush_done (flush_done)
  );

  cache_uncached u_uncached (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_req (uc_req), .i_cmd (uc_cmd), .o_ack (uc_ack), .o_rdata (uc_rdata),
    .o_bus_valid (uc_bus_valid), .o_bus (uc_bus),
    .i_bus_ready (uc_bus_ready), .i_bus_rdata (i_bus_rdata)
  );

  cache_flush u_flush (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_fencei_req (i_fencei_req), .o_fencei_ack (o_fencei_ack),
    .o_flush_req (flush_req), .i_flush_done (flush_done), .o_inval (inval)
  );

endmodule

`default_nettype wire

// File: tb_cache.sv
/* cache subsystem testbench with a line-bus memory model and shadow lines,
   LFSR stimulus, immediate assertions and a cycle limit */
`timescale 1ns/100ps
`default_nettype none

module tb_cache;
  import cache_sys_pkg::*;

  localparam int N_RAND = 300;
  localparam int N_PAIR = 80;
  // about 40 cycles per access plus 40 accesses of fixed tests and fences
  localparam int CYCLE_LIMIT = (N_RAND + 2 * N_PAIR + 40) * 40;

  logic              clk;
  logic              i_arst_n;
  logic              i_if_req;
  logic [ADDR_W-1:0] i_if_addr;
  logic              o_if_ack;
  logic [31:0]       o_if_rdata;
  logic              i_d_req;
  cpu_req_t          i_d_cmd;
  logic              o_d_ack;
  logic [DATA_W-1:0] o_d_rdata;
  logic              i_fencei_req;
  logic              o_fencei_ack;
  logic              o_bus_valid;
  bus_req_t          o_bus_req;
  logic              i_bus_ready;
  logic [LINE_W-1:0] i_bus_rdata;

  int          n_checks    = 0;
  int          err_value   = 0;
  int          err_other   = 0;
  int          n_line_xfer = 0;
  int          n_word_xfer = 0;
  int          cycles      = 0;
  logic [15:0] lfsr_bus    = 16'd84;
  logic [15:0] lfsr_stim   = 16'd84;
  bus_req_t    last_word;

  // keyed by line address
  logic [LINE_W-1:0] mem_lines [logic [ADDR_W-1:0]];
  logic [LINE_W-1:0] shadow    [logic [ADDR_W-1:0]];

  cache_top #(.ICACHE_LINES (16), .DCACHE_LINES (16)) DUT (
    .clk (clk), .i_arst_n (i_arst_n),
    .i_if_req (i_if_req), .i_if_addr (i_if_addr),
    .o_if_ack (o_if_ack), .o_if_rdata (o_if_rdata),
    .i_d_req (i_d_req), .i_d_cmd (i_d_cmd), .o_d_ack (o_d_ack), .o_d_rdata (o_d_rdata),
    .i_fencei_req (i_fencei_req), .o_fencei_ack (o_fencei_ack),
    .o_bus_valid (o_bus_valid), .o_bus_req (o_bus_req),
    .i_bus_ready (i_bus_ready), .i_bus_rdata (i_bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // reference helpers

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [63:0] draw(inout logic [15:0] st, input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      st = lfsr_next(st);
      v  = {v[62:0], st[0]};
    end
    return v;
  endfunction

  function automatic logic [LINE_W-1:0] fill_line(logic [ADDR_W-1:0] la);
    logic [LINE_W-1:0] l;
    logic [ADDR_W-1:0] a;
    for (int w = 0; w < 4; w++) begin
      a = la + ADDR_W'(4 * w);
      l[32*w +: 32] = (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    end
    return l;
  endfunction

  function automatic logic [DATA_W-1:0] peri_word(logic [ADDR_W-1:0] addr);
    return {~addr, addr ^ 32'h5EED_1234};
  endfunction

  function automatic logic is_peri(logic [ADDR_W-1:0] addr);
    return addr[31:28] inside {4'h1, 4'h2};
  endfunction

  function automatic logic [LINE_W-1:0] model_line(logic [ADDR_W-1:0] la);
    if (mem_lines.exists(la)) begin
      return mem_lines[la];
    end
    return fill_line(la);
  endfunction

  function automatic logic [LINE_W-1:0] shadow_line(logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] la;
    la = {addr[31:4], 4'h0};
    if (shadow.exists(la)) begin
      return shadow[la];
    end
    return fill_line(la);
  endfunction

  // value seen by a read at addr with the lowest byte first
  function automatic logic [DATA_W-1:0] load_value(logic [ADDR_W-1:0] addr);
    logic [LINE_W-1:0] l;
    if (is_peri(addr)) begin
      l = LINE_W'(peri_word(addr));
    end else begin
      l = shadow_line(addr) >> (8 * addr[3:0]);
    end
    return l[DATA_W-1:0];
  endfunction

  function automatic logic [DATA_W-1:0] size_mask(logic [2:0] bytes);
    return {DATA_W{1'b1}} >> (8 * (7 - int'(bytes)));
  endfunction

  function automatic cpu_req_t make_cmd(logic op, logic [ADDR_W-1:0] addr,
                                        logic [DATA_W-1:0] wdata, logic [2:0] bytes);
    cpu_req_t c;
    c.op    = op;
    c.addr  = addr;
    c.wdata = wdata;
    c.bytes = bytes;
    return c;
  endfunction

  // aligned access with 4 tags over 16 sets for conflict misses
  function automatic cpu_req_t rand_cmd(logic [ADDR_W-1:0] base);
    logic [63:0] r;
    cpu_req_t    c;
    r       = draw(lfsr_stim, 13);
    c.op    = r[0];
    c.bytes = 3'((4'd1 << r[2:1]) - 4'd1);
    c.addr  = base | ADDR_W'({r[12:11], r[10:7], r[6:3] & ~{1'b0, c.bytes}});
    c.wdata = draw(lfsr_stim, 64);
    return c;
  endfunction

  function automatic void check_value(string name, logic [LINE_W-1:0] want,
                                      logic [LINE_W-1:0] got);
    n_checks++;
    assert (got === want) else begin
      err_value++;
      $display("ERR %s expected %0h actual %0h", name, want, got);
    end
  endfunction

  function automatic void check_true(logic cond, string what);
    n_checks++;
    assert (cond) else begin
      err_other++;
      $display("error: %s", what);
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // memory model with 0 to 3 wait cycles before ready

  function automatic void serve_bus(bus_req_t req);
    logic [ADDR_W-1:0] la;
    la = {req.addr[31:4], 4'h0};
    if (is_peri(req.addr)) begin
      n_word_xfer++;
      last_word = req;
      check_true(req.size < SIZE_LINE, "line transfer to a peripheral address");
      i_bus_rdata = LINE_W'(peri_word(req.addr));
    end else begin
      n_line_xfer++;
      check_true(req.size == SIZE_LINE, "word transfer to a cached address");
      if (req.op == OP_WRITE) begin
        check_value("write-back line", shadow_line(la), req.wdata);
        mem_lines[la] = req.wdata;
      end
      i_bus_rdata = model_line(la);
    end
  endfunction

  initial begin
    int   wait_left;
    logic armed;
    i_bus_ready = 1'b0;
    i_bus_rdata = '0;
    armed       = 1'b0;
    wait_left   = 0;
    forever begin
      @(negedge clk);
      if (i_bus_ready) begin
        i_bus_ready = 1'b0;
      end else if (o_bus_valid) begin
        if (!armed) begin
          wait_left = int'(draw(lfsr_bus, 2));
          armed     = 1'b1;
        end
        if (wait_left == 0) begin
          serve_bus(o_bus_req);
          i_bus_ready = 1'b1;
          armed       = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // cpu side

  task automatic fetch(input logic [ADDR_W-1:0] addr, input string name);
    logic [DATA_W-1:0] want;
    @(negedge clk);
    i_if_req  = 1'b1;
    i_if_addr = addr;
    do @(negedge clk); while (!o_if_ack);
    want = load_value(addr);
    check_value(name, LINE_W'(want[31:0]), LINE_W'(o_if_rdata));
    i_if_req = 1'b0;
  endtask

  task automatic data_access(input cpu_req_t cmd, input string name);
    logic [LINE_W-1:0] l;
    logic [DATA_W-1:0] mask;
    int                off;
    @(negedge clk);
    i_d_req = 1'b1;
    i_d_cmd = cmd;
    do @(negedge clk); while (!o_d_ack);
    mask = size_mask(cmd.bytes);
    off  = int'(cmd.addr[3:0]);
    if (cmd.op == OP_READ) begin
      check_value(name, LINE_W'(load_value(cmd.addr) & mask), LINE_W'(o_d_rdata & mask));
    end else if (!is_peri(cmd.addr)) begin
      l = shadow_line(cmd.addr);
      for (int b = 0; b <= int'(cmd.bytes); b++) begin
        l[8 * (off + b) +: 8] = cmd.wdata[8 * b +: 8];
      end
      shadow[{cmd.addr[31:4], 4'h0}] = l;
    end
    i_d_req = 1'b0;
  endtask

  task automatic peri_data(input cpu_req_t cmd, input string name);
    int words;
    int lines;
    words = n_word_xfer;
    lines = n_line_xfer;
    data_access(cmd, name);
    check_true(n_word_xfer == words + 1, "peripheral access did not make one bus transfer");
    check_true(n_line_xfer == lines, "peripheral access moved a cache line");
    check_value({name, " size"}, LINE_W'($countones(cmd.bytes)), LINE_W'(last_word.size));
    check_value({name, " addr"}, LINE_W'(cmd.addr), LINE_W'(last_word.addr));
    check_value({name, " op"}, LINE_W'(cmd.op), LINE_W'(last_word.op));
    if (cmd.op == OP_WRITE) begin
      check_value({name, " wdata"}, LINE_W'(cmd.wdata & size_mask(cmd.bytes)),
                  LINE_W'(last_word.wdata[DATA_W-1:0] & size_mask(cmd.bytes)));
    end
  endtask

  task automatic fence_i();
    @(negedge clk);
    i_fencei_req = 1'b1;
    do @(negedge clk); while (!o_fencei_ack);
    check_true(!o_bus_valid, "bus still busy at fence.i ack");
    i_fencei_req = 1'b0;
  endtask

  // every stored line must have reached memory
  function automatic void check_memory();
    foreach (shadow[la]) begin
      check_value("memory line after fence.i", shadow[la], model_line(la));
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [63:0]       r;
    logic [ADDR_W-1:0] fa;
    cpu_req_t          cmd;
    int                xfers;
    i_arst_n     = 1'b0;
    i_if_req     = 1'b0;
    i_if_addr    = '0;
    i_d_req      = 1'b0;
    i_d_cmd      = '0;
    i_fencei_req = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;

    repeat (8) begin
      @(negedge clk);
      check_true(!(o_if_ack || o_d_ack || o_fencei_ack || o_bus_valid),
                 "output active after reset with no request");
    end

    // second fetch of a line stays in the icache
    fetch(32'h3000_0040, "fetch flash");
    xfers = n_line_xfer + n_word_xfer;
    fetch(32'h3000_0044, "fetch flash same line");
    check_true(n_line_xfer + n_word_xfer == xfers, "cached flash fetch reached the bus");
    fetch(32'h8001_0200, "fetch memory");
    xfers = n_line_xfer + n_word_xfer;
    fetch(32'h8001_020c, "fetch memory same line");
    check_true(n_line_xfer + n_word_xfer == xfers, "cached memory fetch reached the bus");

    for (int n = 0; n < N_RAND; n++) begin
      data_access(rand_cmd(32'h8000_0000), "random load/store");
    end
    fence_i();
    check_memory();

    peri_data(make_cmd(OP_READ, 32'h1000_0010, '0, 3'd3), "peripheral read");
    peri_data(make_cmd(OP_READ, 32'h1000_0010, '0, 3'd3), "peripheral read again");
    peri_data(make_cmd(OP_WRITE, 32'h2000_0008, 64'h1122_3344_5566_7788, 3'd7),
              "peripheral write");
    peri_data(make_cmd(OP_READ, 32'h2000_0002, '0, 3'd1), "peripheral half");
    peri_data(make_cmd(OP_READ, 32'h1000_0003, '0, 3'd0), "peripheral byte");
    for (int k = 0; k < 2; k++) begin
      xfers = n_word_xfer;
      fetch(32'h2000_0100, "peripheral fetch");
      check_true(n_word_xfer == xfers + 1, "peripheral fetch did not make one bus transfer");
      check_value("peripheral fetch size", LINE_W'(2), LINE_W'(last_word.size));
      check_value("peripheral fetch addr", LINE_W'(32'h2000_0100), LINE_W'(last_word.addr));
      check_value("peripheral fetch op", LINE_W'(OP_READ), LINE_W'(last_word.op));
    end

    // self-modifying code
    fetch(32'h3000_0100, "fetch before code store");
    data_access(make_cmd(OP_WRITE, 32'h3000_0100, 64'h0000_0000_00A5_0513, 3'd3),
                "code store");
    fence_i();
    check_memory();
    fetch(32'h3000_0100, "fetch after fence.i");
    check_value("new code word", LINE_W'(32'h00A5_0513), LINE_W'(o_if_rdata));

    // both channels at once
    for (int n = 0; n < N_PAIR; n++) begin
      r   = draw(lfsr_stim, 10);
      fa  = (r[0] ? 32'h8001_0000 : 32'h3000_0000) | ADDR_W'({r[9:1], 2'b00});
      cmd = rand_cmd(32'h8000_0000);
      fork
        fetch(fa, "paired fetch");
        data_access(cmd, "paired data");
      join
    end

    repeat (4) @(negedge clk);
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, err_value, err_other);
    if (err_value == 0 && err_other == 0 && n_checks > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, err_value, err_other);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: cache_sys.f
cache_sys_pkg.sv
cache_core.sv
cache_uncached.sv
cache_flush.sv
cache_route.sv
cache_top.sv
tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache -f cache_sys.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_cache)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
